// ==== rtl/shared_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shared_fifo_cfg.svh"

module shared_fifo (
  input  wire                                        clk,
  input  wire                                        rst,

  input  wire                                        push_valid,
  output logic                                       push_ready,
  input  shared_fifo_pkg::data_t                     push_data,
  input  shared_fifo_pkg::fifo_id_t                  push_fifo_id,

  output logic [`SF_NUM_FIFOS-1:0]                   pop_valid,
  input  wire  [`SF_NUM_FIFOS-1:0]                   pop_ready,
  output shared_fifo_pkg::data_t [`SF_NUM_FIFOS-1:0] pop_data
);

  logic                   alloc_take;
  shared_fifo_pkg::addr_t alloc_addr;
  logic                   free_valid;
  shared_fifo_pkg::addr_t free_addr;

  logic                   data_we;
  shared_fifo_pkg::addr_t data_waddr;
  shared_fifo_pkg::data_t data_wdata;
  logic                   next_we;
  shared_fifo_pkg::addr_t next_waddr;
  shared_fifo_pkg::addr_t next_wdata;

  logic                   rd_en;
  shared_fifo_pkg::addr_t rd_addr;
  shared_fifo_pkg::data_t rd_data;
  shared_fifo_pkg::addr_t rd_next;

  // push_ready is the pool's availability flag.
  shared_fifo_free_pool free_pool_i (
    .clk        (clk),
    .rst        (rst),
    .alloc_take (alloc_take),
    .alloc_addr (alloc_addr),
    .alloc_avail(push_ready),
    .free_valid (free_valid),
    .free_addr  (free_addr),
    .used_count ()
  );

  shared_fifo_ram #(
    .payload_t(shared_fifo_pkg::data_t),
    .depth    (`SF_DEPTH)
  ) data_ram_i (
    .clk  (clk),
    .we   (data_we),
    .waddr(data_waddr),
    .wdata(data_wdata),
    .re   (rd_en),
    .raddr(rd_addr),
    .rdata(rd_data)
  );

  shared_fifo_ram #(
    .payload_t(shared_fifo_pkg::addr_t),
    .depth    (`SF_DEPTH)
  ) next_ram_i (
    .clk  (clk),
    .we   (next_we),
    .waddr(next_waddr),
    .wdata(next_wdata),
    .re   (rd_en),
    .raddr(rd_addr),
    .rdata(rd_next)
  );

  shared_fifo_queue_ctrl queue_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_fifo_id(push_fifo_id),
    .alloc_addr  (alloc_addr),
    .alloc_avail (push_ready),
    .alloc_take  (alloc_take),
    .free_valid  (free_valid),
    .free_addr   (free_addr),
    .data_we     (data_we),
    .data_waddr  (data_waddr),
    .data_wdata  (data_wdata),
    .next_we     (next_we),
    .next_waddr  (next_waddr),
    .next_wdata  (next_wdata),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .rd_next     (rd_next),
    .pop_valid   (pop_valid),
    .pop_ready   (pop_ready),
    .pop_data    (pop_data)
  );

endmodule

`default_nettype wire

// ==== rtl/shared_fifo_cfg.svh ====
`ifndef SHARED_FIFO_CFG_SVH
`define SHARED_FIFO_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// buffer sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SF_NUM_FIFOS 4  // logical fifos sharing the pool.
`define SF_DEPTH     16 // shared data slots.
`define SF_WIDTH     8  // payload bits.

`endif

// ==== rtl/shared_fifo_free_pool.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shared_fifo_cfg.svh"

module shared_fifo_free_pool (
  input  wire                      clk,
  input  wire                      rst,

  input  wire                      alloc_take,
  output shared_fifo_pkg::addr_t   alloc_addr,
  output logic                     alloc_avail,

  input  wire                      free_valid,
  input  shared_fifo_pkg::addr_t   free_addr,

  output shared_fifo_pkg::count_t  used_count
);

  localparam int DEPTH = `SF_DEPTH;

  logic [DEPTH-1:0] free_q; // one bit per slot that is set while free.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // allocation offer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    alloc_addr = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        alloc_addr = shared_fifo_pkg::addr_t'(i); // lowest index wins.
      end
    end
  end

  assign alloc_avail = (used_count != shared_fifo_pkg::count_t'(DEPTH));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bitmap and count
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      free_q     <= '1;
      used_count <= '0;
    end else begin
      // take and release never hit the same slot.
      if (alloc_take) begin
        free_q[alloc_addr] <= 1'b0;
      end
      if (free_valid) begin
        free_q[free_addr] <= 1'b1;
      end
      case ({alloc_take, free_valid})
        2'b10:   used_count <= used_count + 1'b1;
        2'b01:   used_count <= used_count - 1'b1;
        default: used_count <= used_count;
      endcase
    end
  end

  a_take_when_avail: assert property (
    @(posedge clk) disable iff (rst)
    alloc_take |-> alloc_avail && free_q[alloc_addr]
  );

  a_release_held_slot: assert property (
    @(posedge clk) disable iff (rst)
    free_valid |-> !free_q[free_addr]
  );

endmodule

`default_nettype wire

// ==== rtl/shared_fifo_pkg.sv ====
`default_nettype none

package shared_fifo_pkg;

  `include "shared_fifo_cfg.svh"

  localparam int FIFO_ID_W = $clog2(`SF_NUM_FIFOS);
  localparam int ADDR_W    = $clog2(`SF_DEPTH);
  localparam int COUNT_W   = ADDR_W + 1; // holds 0..SF_DEPTH.

  typedef logic [FIFO_ID_W-1:0] fifo_id_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [COUNT_W-1:0]   count_t;
  typedef logic [`SF_WIDTH-1:0] data_t;

endpackage

`default_nettype wire

// ==== rtl/shared_fifo_queue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shared_fifo_cfg.svh"

module shared_fifo_queue_ctrl (
  input  wire                                        clk,
  input  wire                                        rst,

  input  wire                                        push_valid,
  input  shared_fifo_pkg::data_t                     push_data,
  input  shared_fifo_pkg::fifo_id_t                  push_fifo_id,

  input  shared_fifo_pkg::addr_t                     alloc_addr,
  input  wire                                        alloc_avail,
  output logic                                       alloc_take,

  output logic                                       free_valid,
  output shared_fifo_pkg::addr_t                     free_addr,

  output logic                                       data_we,
  output shared_fifo_pkg::addr_t                     data_waddr,
  output shared_fifo_pkg::data_t                     data_wdata,

  output logic                                       next_we,
  output shared_fifo_pkg::addr_t                     next_waddr,
  output shared_fifo_pkg::addr_t                     next_wdata,

  output logic                                       rd_en,
  output shared_fifo_pkg::addr_t                     rd_addr,
  input  shared_fifo_pkg::data_t                     rd_data,
  input  shared_fifo_pkg::addr_t                     rd_next,

  output logic [`SF_NUM_FIFOS-1:0]                   pop_valid,
  input  wire  [`SF_NUM_FIFOS-1:0]                   pop_ready,
  output shared_fifo_pkg::data_t [`SF_NUM_FIFOS-1:0] pop_data
);

  localparam int NF = `SF_NUM_FIFOS;

  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_LOADING,
    ST_FULL
  } stage_state_t;

  // per fifo list and stage state.
  shared_fifo_pkg::addr_t  tail_q       [NF];
  shared_fifo_pkg::addr_t  rptr_q       [NF];
  shared_fifo_pkg::count_t unread_q     [NF];
  stage_state_t            state_q      [NF];
  shared_fifo_pkg::data_t  stage_data_q [NF];
  shared_fifo_pkg::addr_t  stage_slot_q [NF];
  shared_fifo_pkg::addr_t  pend_addr_q  [NF];
  logic [NF-1:0]           pend_q;       // popped slot still waiting for release.

  shared_fifo_pkg::fifo_id_t rr_q;
  shared_fifo_pkg::fifo_id_t rel_rr_q;
  shared_fifo_pkg::fifo_id_t grant_id;
  shared_fifo_pkg::fifo_id_t rel_id;
  logic                      rd_last_q;  // in-flight read took the last unread entry.

  logic [NF-1:0] push_hit;
  logic [NF-1:0] rd_hit;
  logic [NF-1:0] list_empty;
  logic [NF-1:0] eligible;
  logic [NF-1:0] pop_fire;
  logic [NF-1:0] rel_req;
  logic [NF-1:0] rel_grant;

  // first requester from start onward with wraparound.
  function automatic shared_fifo_pkg::fifo_id_t rr_pick(input logic [NF-1:0] req,
                                                        input shared_fifo_pkg::fifo_id_t start);
    shared_fifo_pkg::fifo_id_t pick;
    int unsigned               idx;
    pick = start;
    for (int k = NF - 1; k >= 0; k--) begin
      idx = (int'(start) + k) % NF;
      if (req[idx]) begin
        pick = shared_fifo_pkg::fifo_id_t'(idx);
      end
    end
    return pick;
  endfunction

  function automatic shared_fifo_pkg::fifo_id_t rr_next(input shared_fifo_pkg::fifo_id_t id);
    return (int'(id) == NF - 1) ? '0 : id + 1'b1;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // push, refill and release decisions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign alloc_take = push_valid && alloc_avail;

  always_comb begin
    for (int f = 0; f < NF; f++) begin
      pop_valid[f] = (state_q[f] == ST_FULL) && !pend_q[f];
      pop_data[f]  = stage_data_q[f];
      pop_fire[f]  = pop_valid[f] && pop_ready[f];
      eligible[f]  = (unread_q[f] != '0) && ((state_q[f] == ST_EMPTY) || pop_fire[f]);
      push_hit[f]  = alloc_take && (push_fifo_id == shared_fifo_pkg::fifo_id_t'(f));
      rel_req[f]   = pend_q[f] || pop_fire[f];
    end
  end

  assign rd_en    = |eligible;
  assign grant_id = rr_pick(eligible, rr_q);
  assign rd_addr  = rptr_q[grant_id];

  always_comb begin
    for (int f = 0; f < NF; f++) begin
      rd_hit[f] = rd_en && (grant_id == shared_fifo_pkg::fifo_id_t'(f));
      // the last unread entry leaving now counts as an empty list.
      list_empty[f] = (unread_q[f] == '0) ||
                      ((unread_q[f] == shared_fifo_pkg::count_t'(1)) && rd_hit[f]);
    end
  end

  assign data_we    = alloc_take;
  assign data_waddr = alloc_addr;
  assign data_wdata = push_data;

  assign next_we    = alloc_take && !list_empty[push_fifo_id];
  assign next_waddr = tail_q[push_fifo_id];
  assign next_wdata = alloc_addr;

  assign free_valid = |rel_req;
  assign rel_id     = rr_pick(rel_req, rel_rr_q);
  assign free_addr  = pend_q[rel_id] ? pend_addr_q[rel_id] : stage_slot_q[rel_id];

  always_comb begin
    for (int f = 0; f < NF; f++) begin
      rel_grant[f] = free_valid && (rel_id == shared_fifo_pkg::fifo_id_t'(f));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int f = 0; f < NF; f++) begin
        unread_q[f] <= '0;
        state_q[f]  <= ST_EMPTY;
      end
      pend_q    <= '0;
      rr_q      <= '0;
      rel_rr_q  <= '0;
      rd_last_q <= 1'b0;
    end else begin
      for (int f = 0; f < NF; f++) begin
        case ({push_hit[f], rd_hit[f]})
          2'b10:   unread_q[f] <= unread_q[f] + 1'b1;
          2'b01:   unread_q[f] <= unread_q[f] - 1'b1;
          default: unread_q[f] <= unread_q[f];
        endcase

        case (state_q[f])
          ST_EMPTY:   if (rd_hit[f]) state_q[f] <= ST_LOADING;
          ST_LOADING: state_q[f] <= ST_FULL; // read data lands this cycle.
          ST_FULL:    if (pop_fire[f]) state_q[f] <= rd_hit[f] ? ST_LOADING : ST_EMPTY;
          default:    state_q[f] <= ST_EMPTY;
        endcase

        if (rel_grant[f]) begin
          pend_q[f] <= 1'b0;
        end else if (pop_fire[f]) begin
          pend_q[f] <= 1'b1;
        end
      end

      if (rd_en) begin
        rr_q      <= rr_next(grant_id);
        rd_last_q <= (unread_q[grant_id] == shared_fifo_pkg::count_t'(1));
      end
      if (free_valid) begin
        rel_rr_q <= rr_next(rel_id);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and stage payload
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    for (int f = 0; f < NF; f++) begin
      if (push_hit[f]) begin
        tail_q[f] <= alloc_addr;
      end
      if (push_hit[f] && list_empty[f]) begin
        rptr_q[f] <= alloc_addr; // next pointer of the old tail is never read.
      end else if ((state_q[f] == ST_LOADING) && !rd_last_q) begin
        rptr_q[f] <= rd_next;
      end
      if (rd_hit[f]) begin
        stage_slot_q[f] <= rd_addr;
      end
      if (state_q[f] == ST_LOADING) begin
        stage_data_q[f] <= rd_data;
      end
      if (pop_fire[f] && !rel_grant[f]) begin
        pend_addr_q[f] <= stage_slot_q[f];
      end
    end
  end

  // a loading stage presents the word just read on the next cycle.
  for (genvar g = 0; g < NF; g++) begin : g_stage_chk
    a_load_to_full: assert property (
      @(posedge clk) disable iff (rst)
      (state_q[g] == ST_LOADING) |=>
        (pop_valid[g] || pend_q[g]) && (pop_data[g] == $past(rd_data))
    );
  end

endmodule

`default_nettype wire

// ==== rtl/shared_fifo_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_fifo_ram #(
  parameter type payload_t = logic,
  parameter int  depth     = 16
) (
  input  wire                      clk,

  input  wire                      we,
  input  shared_fifo_pkg::addr_t   waddr,
  input  payload_t                 wdata,

  input  wire                      re,
  input  shared_fifo_pkg::addr_t   raddr,
  output payload_t                 rdata
);

  payload_t mem [depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read returns the old word on a same-edge write to raddr.
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the shared FIFO testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f shared_fifo.f \
  --top-module shared_fifo_tb \
  --Mdir "$OBJ_DIR" \
  -o shared_fifo_sim

"./$OBJ_DIR/shared_fifo_sim" | tee "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  echo "simulation reported errors, see $LOG"
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation finished cleanly"

// ==== shared_fifo.f ====
+incdir+rtl
rtl/shared_fifo_pkg.sv
rtl/shared_fifo_ram.sv
rtl/shared_fifo_free_pool.sv
rtl/shared_fifo_queue_ctrl.sv
rtl/shared_fifo.sv
sim/shared_fifo_tb.sv

// ==== sim/shared_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shared_fifo_cfg.svh"

module shared_fifo_tb;

  localparam int NF      = `SF_NUM_FIFOS;
  localparam int ID_W    = shared_fifo_pkg::FIFO_ID_W;
  localparam int TIMEOUT = 1000; // cycles allowed per wait.

  logic                            clk;
  logic                            rst;
  logic                            push_valid;
  logic                            push_ready;
  shared_fifo_pkg::data_t          push_data;
  shared_fifo_pkg::fifo_id_t       push_fifo_id;
  logic [NF-1:0]                   pop_valid;
  logic [NF-1:0]                   pop_ready;
  shared_fifo_pkg::data_t [NF-1:0] pop_data;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  logic   pop_random = 1'b0; // redraw pop_ready every cycle.
  int     only_port  = -1;   // -1 lets every port pop.

  shared_fifo_pkg::data_t ref_q     [NF][$]; // expected words per fifo.
  logic [NF-1:0]          held = '0;
  shared_fifo_pkg::data_t held_data [NF];

  shared_fifo shared_fifo_i (
    .clk         (clk),
    .rst         (rst),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .push_data   (push_data),
    .push_fifo_id(push_fifo_id),
    .pop_valid   (pop_valid),
    .pop_ready   (pop_ready),
    .pop_data    (pop_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    errors++;
    $display("ERROR: timed out waiting for %s", what);
    finish_run();
  endtask

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // oldest word still owed by a fifo.
  function automatic shared_fifo_pkg::data_t expected_front(input int f);
    return ref_q[f][0];
  endfunction

  function automatic int queued_total();
    int total;
    total = 0;
    for (int f = 0; f < NF; f++) begin
      total += ref_q[f].size();
    end
    return total;
  endfunction

  task automatic next_cycle();
    logic [31:0] rnd;
    @(posedge clk);
    #1;
    if (pop_random) begin
      rnd = rand_word();
      pop_ready = rnd[NF-1:0];
    end
  endtask

  task automatic push_word(input shared_fifo_pkg::fifo_id_t id,
                           input shared_fifo_pkg::data_t data);
    int   waited;
    logic accepted;
    waited       = 0;
    accepted     = 1'b0;
    push_valid   = 1'b1;
    push_fifo_id = id;
    push_data    = data;
    while (!accepted) begin
      @(negedge clk);
      accepted = push_ready; // transfer happens on the coming edge.
      next_cycle();
      waited++;
      if (!accepted && waited > TIMEOUT) begin
        timeout_fail("push_ready to accept a push");
      end
    end
    push_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (queued_total() != 0) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) begin
        timeout_fail("all FIFOs to drain");
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor, sampled mid-cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    if (rst) begin
      held = '0;
    end else begin
      for (int f = 0; f < NF; f++) begin
        if (held[f]) begin // stalled last cycle, must not move.
          check_value($sformatf("pop_valid[%0d]", f), 32'(pop_valid[f]), 32'd1);
          check_value($sformatf("pop_data[%0d]", f), 32'(pop_data[f]), 32'(held_data[f]));
        end
        held[f]      = pop_valid[f] && !pop_ready[f];
        held_data[f] = pop_data[f];
        if (pop_valid[f] && only_port >= 0 && f != only_port) begin
          errors++;
          $display("ERROR: pop_valid raised on port %0d, only port %0d has data", f, only_port);
        end
        if (pop_valid[f] && pop_ready[f]) begin
          if (ref_q[f].size() == 0) begin
            errors++;
            $display("ERROR: port %0d popped a word that was never pushed", f);
          end else begin
            check_value($sformatf("pop_data[%0d]", f), 32'(pop_data[f]),
                        32'(expected_front(f)));
            void'(ref_q[f].pop_front());
          end
        end
      end
      if (push_valid && push_ready) begin
        ref_q[push_fifo_id].push_back(push_data);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [31:0] rnd;
    int          accepted;
    int          waited;
    int          port;
    logic        stop;
    seed         = 52171;
    rst          = 1'b1;
    push_valid   = 1'b0;
    push_data    = '0;
    push_fifo_id = '0;
    pop_ready    = '0;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;

    check_value("pop_valid", 32'(pop_valid), 32'd0);
    check_value("push_ready", 32'(push_ready), 32'd1);

    // single fifo, in order on port 2 only.
    pop_ready = '1;
    only_port = 2;
    for (int i = 0; i < 8; i++) begin
      rnd = rand_word();
      push_word(shared_fifo_pkg::fifo_id_t'(2), rnd[`SF_WIDTH-1:0]);
    end
    wait_drain();
    next_cycle();
    only_port = -1;

    // mixed traffic with random gaps and back-pressure.
    pop_random = 1'b1;
    for (int i = 0; i < 400; i++) begin
      rnd = rand_word();
      repeat (int'(rnd[17:16])) next_cycle();
      push_word(rnd[ID_W-1:0], rnd[`SF_WIDTH-1:0]);
    end
    pop_random = 1'b0;
    pop_ready  = '1;
    wait_drain();
    next_cycle();
    check_value("pop_valid", 32'(pop_valid), 32'd0);

    // fill every slot with the outputs stalled.
    pop_ready  = '0;
    push_valid = 1'b1;
    accepted   = 0;
    waited     = 0;
    stop       = 1'b0;
    while (!stop) begin
      rnd          = rand_word();
      push_fifo_id = rnd[ID_W-1:0];
      push_data    = rnd[`SF_WIDTH-1:0];
      @(negedge clk);
      if (push_ready) begin
        accepted++;
      end else begin
        stop = 1'b1;
      end
      next_cycle();
      waited++;
      if (!stop && waited > `SF_DEPTH + TIMEOUT) begin
        timeout_fail("push_ready to fall with the pool full");
      end
    end
    push_valid = 1'b0;
    check_value("accepted pushes", 32'(accepted), 32'(`SF_DEPTH));

    waited = 0;
    while (pop_valid == '0) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) begin
        timeout_fail("an output stage to fill");
      end
    end
    port = 0;
    for (int f = NF - 1; f >= 0; f--) begin
      if (pop_valid[f]) begin
        port = f;
      end
    end
    check_value("push_ready", 32'(push_ready), 32'd0);
    pop_ready[port] = 1'b1; // exactly one pop.
    next_cycle();
    pop_ready = '0;
    check_value("push_ready", 32'(push_ready), 32'd1);
    rnd = rand_word();
    push_word(rnd[ID_W-1:0], rnd[`SF_WIDTH-1:0]);
    check_value("push_ready", 32'(push_ready), 32'd0);

    pop_ready = '1;
    wait_drain();
    next_cycle();
    finish_run();
  end

endmodule

`default_nettype wire
